/* array_feeder_top.sv */
`timescale 1ns/1ps
`default_nettype none

// coefficient bank feeder for the systolic array
// unpacker and sequencer side by side, placer combines them
module array_feeder_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  feeder_pkg::bank_bus_t banks,
    output feeder_pkg::feed_bus_t rows
);

    // sign-extended taps, same cycle as banks
    feeder_pkg::tap_bus_t taps;

    // all eight valid flags high
    logic                 all_valid;

    // window offset held before the current edge
    feeder_pkg::phase_t   phase;

    coef_unpack unpack_i (
        .banks     (banks),
        .taps      (taps),
        .all_valid (all_valid)
    );

    phase_sequencer seq_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .all_valid (all_valid),
        .phase     (phase)
    );

    window_placer place_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .phase     (phase),
        .taps      (taps),
        .rows      (rows)
    );

endmodule

`default_nettype wire

/* coef_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "feeder_defs.svh"

// splits the bank words into sign-extended taps
// and reports whether every bank holds valid data
module coef_unpack (
    input  feeder_pkg::bank_bus_t banks,
    output feeder_pkg::tap_bus_t  taps,
    output logic                  all_valid
);

    // per-bank valid flags pulled out of the words
    logic [`FEED_BANKS-1:0] valid_vec;

    // sign extension of every tap in every bank
    always_comb begin
        for (int b = 0; b < `FEED_BANKS; b++) begin
            for (int k = 0; k < `FEED_TAPS; k++) begin
                taps[b][k] = {
                    {(`FEED_DATA_W - `FEED_COE_W){banks[b].coef[k][`FEED_COE_W-1]}},
                    banks[b].coef[k]
                };
            end
        end
    end

    // gather the flags
    always_comb begin
        for (int b = 0; b < `FEED_BANKS; b++) begin
            valid_vec[b] = banks[b].valid;
        end
    end

    // the offset may only move when every bank is ready
    assign all_valid = &valid_vec;

endmodule

`default_nettype wire

/* feeder_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "feeder_defs.svh"

// reference model of the feeder
// samples the DUT inputs on every rising edge and predicts rows one cycle later
module feeder_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  feeder_pkg::bank_bus_t banks,
    input  feeder_pkg::feed_bus_t rows,
    output int                    errors
);

    // expected rows after the last sampled edge
    feeder_pkg::feed_bus_t model_rows;

    // model window offset, 0..2
    int                    model_phase;

    // set once the first reset edge has been seen
    logic                  model_live;

    // 9-bit two's complement value to 16 bits, done arithmetically
    function automatic logic [`FEED_DATA_W-1:0] extend(input logic [`FEED_COE_W-1:0] raw);
        int value;
        value = int'(raw);
        if (value >= (1 << (`FEED_COE_W - 1))) begin
            value = value - (1 << `FEED_COE_W);
        end
        return value[`FEED_DATA_W-1:0];
    endfunction

    // true when no bank has its flag low
    function automatic logic banks_ready(input feeder_pkg::bank_bus_t bus);
        logic ready;
        ready = 1'b1;
        for (int b = 0; b < `FEED_BANKS; b++) begin
            if (!bus[b].valid) begin
                ready = 1'b0;
            end
        end
        return ready;
    endfunction

    // rows seen before this edge against the prediction from the previous one
    task automatic compare_rows();
        for (int b = 0; b < `FEED_BANKS; b++) begin
            for (int c = 0; c < `FEED_COLS; c++) begin
                if (rows[b][c] !== model_rows[b][c]) begin
                    errors++;
                    $display("Fail t=%0t rows[%0d][%0d] expected %h actual %h",
                             $time, b, c, model_rows[b][c], rows[b][c]);
                end
            end
        end
    endtask

    // apply the sampled inputs to the model state
    task automatic update_model();
        if (!rst_n) begin
            model_rows  = '0;
            model_phase = 0;
            model_live  = 1'b1;
        end else if (enable) begin
            for (int b = 0; b < `FEED_BANKS; b++) begin
                for (int c = 0; c < `FEED_COLS; c++) begin
                    if (c >= model_phase && c < model_phase + `FEED_TAPS) begin
                        model_rows[b][c] = extend(banks[b].coef[c - model_phase]);
                    end else begin
                        model_rows[b][c] = '0;
                    end
                end
            end
            // offset only moves with every bank valid
            if (banks_ready(banks)) begin
                if (model_phase == `FEED_PHASES - 1) begin
                    model_phase = 0;
                end else begin
                    model_phase = model_phase + 1;
                end
            end
        end
    endtask

    initial begin
        errors      = 0;
        model_live  = 1'b0;
        model_phase = 0;
        model_rows  = '0;
    end

    // inputs still hold the values the DUT sampled at this edge
    always @(posedge clk) begin
        if (model_live) begin
            compare_rows();
        end
        update_model();
    end

endmodule

`default_nettype wire

/* feeder_defs.svh */
`ifndef FEEDER_DEFS_SVH
`define FEEDER_DEFS_SVH

// coefficient width as stored in the bank words
`define FEED_COE_W 9

// sample width seen by the systolic array
`define FEED_DATA_W 16

// coefficients per bank word
`define FEED_TAPS 3

// one bank per array row
`define FEED_BANKS 8

// window offsets 0..2
`define FEED_PHASES 3

// taps + phases - 1
`define FEED_COLS 5

`endif

/* feeder_pkg.sv */
`default_nettype none

`include "feeder_defs.svh"

package feeder_pkg;

    // raw signed coefficient from a bank
    typedef logic signed [`FEED_COE_W-1:0] coef_t;

    // sign-extended sample for the array
    typedef logic signed [`FEED_DATA_W-1:0] sample_t;

    // one bank word, 28 bits
    // valid sits above the taps, tap 0 in the lowest bits
    typedef struct packed {
        logic                      valid;
        coef_t [`FEED_TAPS-1:0]    coef;
    } bank_word_t;

    // all eight bank words side by side, 224 bits
    typedef bank_word_t [`FEED_BANKS-1:0] bank_bus_t;

    // one row's taps after sign extension
    typedef sample_t [`FEED_TAPS-1:0] tap_row_t;

    // taps for every row
    typedef tap_row_t [`FEED_BANKS-1:0] tap_bus_t;

    // window offset, only 0..2 are legal
    typedef logic [1:0] phase_t;

    // one row of array input, column 0 lowest
    typedef sample_t [`FEED_COLS-1:0] feed_row_t;

    // full array input, 640 bits
    typedef feed_row_t [`FEED_BANKS-1:0] feed_bus_t;

endpackage

`default_nettype wire

/* phase_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "feeder_defs.svh"

// window offset register
// steps 0, 1, 2, 0 on enabled edges with all banks valid
module phase_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    input  logic                all_valid,
    output feeder_pkg::phase_t  phase
);

    // the offset moves only on this condition
    logic               advance;

    // offset the register takes on an advance
    feeder_pkg::phase_t phase_next;

    assign advance = enable && all_valid;

    // wrap after the last legal offset
    always_comb begin
        if (phase == feeder_pkg::phase_t'(`FEED_PHASES - 1)) begin
            phase_next = '0;
        end else begin
            phase_next = phase + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (advance) begin
            phase <= phase_next;
        end
    end

    // the fourth encoding is never reached
    a_phase_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        phase < `FEED_PHASES
    ) else $error("phase left the legal range: %0d", phase);

    // a dropped enable freezes the offset for the next cycle
    a_phase_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !enable |=> $stable(phase)
    ) else $error("phase moved across an edge without enable");

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
feeder_pkg.sv
coef_unpack.sv
phase_sequencer.sv
window_placer.sv
array_feeder_top.sv
feeder_checker.sv
tb_array_feeder.sv

/* tb_array_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "feeder_defs.svh"

module tb_array_feeder;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES  = 2;
    localparam int DRAIN_CYCLES  = 2;
    localparam int TEST_COUNT    = 5;

    // cycles driven by each test
    localparam int RESET_LEN     = 16;
    localparam int ROTATE_LEN    = 24;
    localparam int GATED_LEN     = 60;
    localparam int HOLD_LEN      = 60;
    localparam int SIGN_LEN      = 40;

    localparam int TOTAL_CYCLES  = RESET_CYCLES + RESET_LEN + ROTATE_LEN + GATED_LEN
                                 + HOLD_LEN + SIGN_LEN + TEST_COUNT * DRAIN_CYCLES;
    localparam int MARGIN_CYCLES = 50;
    localparam int WATCHDOG_NS   = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    localparam logic [31:0] LFSR_SEED = 32'h3ef16274;

    logic                  clk;
    logic                  rst_n;
    logic                  enable;
    feeder_pkg::bank_bus_t banks;
    feeder_pkg::feed_bus_t rows;

    // running mismatch count from the checker
    int                    check_errors;

    logic [31:0]           lfsr_state;
    int                    tests_done;
    int                    errors_before;

    array_feeder_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .banks  (banks),
        .rows   (rows)
    );

    feeder_checker check_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .banks  (banks),
        .rows   (rows),
        .errors (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // random coefficients, flags either forced high or low one time in eight
    function automatic feeder_pkg::bank_bus_t random_banks(input logic force_valid);
        feeder_pkg::bank_bus_t bus;
        for (int b = 0; b < `FEED_BANKS; b++) begin
            for (int k = 0; k < `FEED_TAPS; k++) begin
                bus[b].coef[k] = feeder_pkg::coef_t'(rand_bits(`FEED_COE_W));
            end
            if (force_valid) begin
                bus[b].valid = 1'b1;
            end else begin
                bus[b].valid = (rand_bits(3) != 0);
            end
        end
        return bus;
    endfunction

    // extreme coefficient values only
    function automatic feeder_pkg::bank_bus_t corner_banks();
        feeder_pkg::bank_bus_t bus;
        logic [1:0]            pick;
        for (int b = 0; b < `FEED_BANKS; b++) begin
            for (int k = 0; k < `FEED_TAPS; k++) begin
                pick = 2'(rand_bits(2));
                case (pick)
                    2'd0:    bus[b].coef[k] = feeder_pkg::coef_t'(255);
                    2'd1:    bus[b].coef[k] = feeder_pkg::coef_t'(-256);
                    2'd2:    bus[b].coef[k] = feeder_pkg::coef_t'(-1);
                    default: bus[b].coef[k] = feeder_pkg::coef_t'(0);
                endcase
            end
            bus[b].valid = 1'b1;
        end
        return bus;
    endfunction

    task automatic drive(input logic en, input feeder_pkg::bank_bus_t bus);
        @(posedge clk);
        enable <= en;
        banks  <= bus;
    endtask

    // let the last drive reach the checker, then report the test
    task automatic end_test(input string name);
        int new_errors;
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        new_errors = check_errors - errors_before;
        tests_done++;
        if (new_errors == 0) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d mismatches", tests_done, name, new_errors);
        end
        errors_before = check_errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        enable        = 1'b0;
        banks         = '0;
        lfsr_state    = LFSR_SEED;
        tests_done    = 0;
        errors_before = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // rows must stay clear while enable is low
        for (int i = 0; i < RESET_LEN; i++) begin
            drive(1'b0, random_banks(1'b1));
        end
        end_test("reset state");

        for (int i = 0; i < ROTATE_LEN; i++) begin
            drive(1'b1, random_banks(1'b1));
        end
        end_test("placement and rotation");

        for (int i = 0; i < GATED_LEN; i++) begin
            drive(1'b1, random_banks(1'b0));
        end
        end_test("gated advance");

        for (int i = 0; i < HOLD_LEN; i++) begin
            drive(1'(rand_bits(1)), random_banks(1'b0));
        end
        end_test("enable hold");

        for (int i = 0; i < SIGN_LEN; i++) begin
            drive(1'b1, corner_banks());
        end
        end_test("sign extension");

        $display("%0d tests run, %0d errors", tests_done, check_errors);
        if (check_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* window_placer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "feeder_defs.svh"

// output registers for the systolic array
// each row gets its three taps at columns phase..phase+2
module window_placer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  feeder_pkg::phase_t    phase,
    input  feeder_pkg::tap_bus_t  taps,
    output feeder_pkg::feed_bus_t rows
);

    // placement for the current phase, before the register
    feeder_pkg::feed_bus_t placed;

    // columns outside the window stay zero
    always_comb begin
        placed = '0;
        for (int b = 0; b < `FEED_BANKS; b++) begin
            for (int k = 0; k < `FEED_TAPS; k++) begin
                placed[b][phase + k] = taps[b][k];
            end
        end
    end

    // rows hold whenever enable is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rows <= '0;
        end else if (enable) begin
            rows <= placed;
        end
    end

    // window edges must come out clear in every row,
    // checked against the phase that was used for the write
    for (genvar b = 0; b < `FEED_BANKS; b++) begin : g_edge_chk

        // column below the window, exists for phase 1 and 2
        a_below_clear: assert property (
            @(posedge clk) disable iff (!rst_n)
            (enable && phase != '0)
            |=> rows[b][$past(phase) - 2'd1] == '0
        ) else $error("row %0d: column below the window is not zero", b);

        // column above the window, exists for phase 0 and 1
        a_above_clear: assert property (
            @(posedge clk) disable iff (!rst_n)
            (enable && (phase + `FEED_TAPS < `FEED_COLS))
            |=> rows[b][$past(phase) + `FEED_TAPS] == '0
        ) else $error("row %0d: column above the window is not zero", b);

    end

endmodule

`default_nettype wire
